// ==== verilog/mmap_params.svh ====
// address window codes, native register constants, array depths and wait-state macros
`ifndef MMAP_PARAMS_SVH
`define MMAP_PARAMS_SVH

// region codes compared with addr[31:24]
`define FLASH_START       8'h00
`define NATV_IP_START     8'h10
`define CUST_IP_START     8'h20
`define PSRAM_START       8'h40

// native register block
`define NATV_ID           32'hA5C0_0101
`define NATV_REGS         8

// array depths in 32-bit words
`define MMAP_WORDS        64
`define PSRAM_WORDS       256

// cycles from valid to ready
`define FLASH_WAIT        3
`define CUST_WAIT         1
`define PSRAM_WAIT        2
`define PSRAM_ROW_PENALTY 3

`endif

// ==== verilog/soc_bus_pkg.sv ====
// native memory port request and response structs, decoded address union
package soc_bus_pkg;

  // core to target request, zero wstrb is a read
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } mem_req_t;

  // target to core response
  // rdata only meaningful while ready is high
  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } mem_rsp_t;

  // region byte on top, byte offset inside the window below
  typedef struct packed {
    logic [7:0]  region;
    logic [23:0] offset;
  } bus_addr_fields_t;

  // the bus looks at region, targets index through offset
  typedef union packed {
    logic [31:0]      raw;
    bus_addr_fields_t f;
  } bus_addr_u;

  // not a struct member, just keeps the field widths honest
  localparam int ADDR_W = $bits(bus_addr_u);

endpackage

// ==== verilog/bus.sv ====
// combinational address decoder and response multiplexer for three memory targets
`timescale 1ns/1ns

`include "mmap_params.svh"

module bus
  import soc_bus_pkg::*;
(
  // core side
  input  mem_req_t core_req_i,
  output mem_rsp_t core_rsp_o,
  // native IP registers
  output mem_req_t natv_req_o,
  input  mem_rsp_t natv_rsp_i,
  // flash and custom IP windows
  output mem_req_t mmap_req_o,
  input  mem_rsp_t mmap_rsp_i,
  // PSRAM
  output mem_req_t psram_req_o,
  input  mem_rsp_t psram_rsp_i
);

  bus_addr_u core_addr;
  logic      natv_sel;
  logic      mmap_sel;
  logic      psram_sel;
  logic      natv_done;
  logic      mmap_done;
  logic      psram_done;

  assign core_addr = core_req_i.addr;

  // region decode on the top address byte
  assign natv_sel  = core_addr.f.region == `NATV_IP_START;
  assign mmap_sel  = (core_addr.f.region == `FLASH_START) ||
                     (core_addr.f.region == `CUST_IP_START);
  assign psram_sel = core_addr.f.region == `PSRAM_START;

  // every target sees the payload, only the selected one sees valid
  always_comb begin
    natv_req_o        = core_req_i;
    natv_req_o.valid  = core_req_i.valid && natv_sel;
    mmap_req_o        = core_req_i;
    mmap_req_o.valid  = core_req_i.valid && mmap_sel;
    psram_req_o       = core_req_i;
    psram_req_o.valid = core_req_i.valid && psram_sel;
  end

  // a target completes only while it is the selected one
  assign natv_done  = natv_req_o.valid && natv_rsp_i.ready;
  assign mmap_done  = mmap_req_o.valid && mmap_rsp_i.ready;
  assign psram_done = psram_req_o.valid && psram_rsp_i.ready;

  always_comb begin
    core_rsp_o.ready = natv_done || mmap_done || psram_done;
    if (natv_done) begin
      core_rsp_o.rdata = natv_rsp_i.rdata;
    end else if (mmap_done) begin
      core_rsp_o.rdata = mmap_rsp_i.rdata;
    end else if (psram_done) begin
      core_rsp_o.rdata = psram_rsp_i.rdata;
    end else begin
      core_rsp_o.rdata = '0;
    end
  end

endmodule

// ==== verilog/natv_regs.sv ====
// native IP register block: read-only identification word and byte-writable scratch registers
`timescale 1ns/1ns

`include "mmap_params.svh"

module natv_regs
  import soc_bus_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  mem_req_t req_i,
  output mem_rsp_t rsp_o
);

  localparam int IDX_W = $clog2(`NATV_REGS);

  bus_addr_u        addr;
  logic [21:0]      word;
  logic [IDX_W-1:0] idx;
  logic             is_id;
  logic             is_write;
  logic             accept;
  logic             ready_q;
  logic [31:0]      rdata_q;
  logic [31:0]      scratch_q [`NATV_REGS];

  assign addr     = req_i.addr;
  assign word     = addr.f.offset[23:2];
  // scratch offsets wrap on the register count
  assign idx      = word[IDX_W-1:0];
  assign is_id    = word == '0;
  assign is_write = |req_i.wstrb;

  // ready_q doubles as the busy flag, so a valid still held
  // in the ready cycle is not taken as a second request
  assign accept = req_i.valid && !ready_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ready_q <= 1'b0;
      for (int i = 0; i < `NATV_REGS; i++) begin
        scratch_q[i] <= '0;
      end
    end else begin
      ready_q <= accept;
      // identification word ignores writes
      if (accept && is_write && !is_id) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.wstrb[b]) begin
            scratch_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  // read data captured with the request, presented with ready
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= is_id ? `NATV_ID : scratch_q[idx];
    end
  end

  assign rsp_o.ready = ready_q;
  assign rsp_o.rdata = rdata_q;

endmodule

// ==== verilog/mmap_mem.sv ====
// memory-mapped target: read-only flash window and custom IP scratch window with fixed waits
`timescale 1ns/1ns

`include "mmap_params.svh"

module mmap_mem
  import soc_bus_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  mem_req_t req_i,
  output mem_rsp_t rsp_o
);

  localparam int IDX_W    = $clog2(`MMAP_WORDS);
  localparam int MAX_WAIT = (`FLASH_WAIT > `CUST_WAIT) ? `FLASH_WAIT : `CUST_WAIT;
  localparam int CNT_W    = $clog2(MAX_WAIT + 1);

  bus_addr_u        addr;
  logic [IDX_W-1:0] idx;
  logic             is_flash;
  logic             is_write;
  logic             accept;
  logic             done;
  logic [CNT_W-1:0] wait_ld;
  logic             busy_q;
  logic [CNT_W-1:0] cnt_q;
  logic [31:0]      flash_q [`MMAP_WORDS];
  logic [31:0]      cust_q [`MMAP_WORDS];

  assign addr     = req_i.addr;
  // word index, wraps on the array depth
  assign idx      = addr.f.offset[IDX_W+1:2];
  // the bus only forwards flash or custom codes here
  assign is_flash = addr.f.region == `FLASH_START;
  assign is_write = |req_i.wstrb;

  // the counter holds the remaining waits minus the ready cycle
  assign wait_ld = is_flash ? CNT_W'(`FLASH_WAIT - 1) : CNT_W'(`CUST_WAIT - 1);

  assign accept = req_i.valid && !busy_q;
  assign done   = busy_q && (cnt_q == '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (accept) begin
      busy_q <= 1'b1;
      cnt_q  <= wait_ld;
    end else if (done) begin
      busy_q <= 1'b0;
    end else if (busy_q) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // flash image: index in the low half, its inverse in the high half
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `MMAP_WORDS; i++) begin
        flash_q[i] <= {~i[15:0], i[15:0]};
      end
    end
  end

  // custom scratch words, byte lanes under wstrb
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `MMAP_WORDS; i++) begin
        cust_q[i] <= '0;
      end
    end else if (done && is_write && !is_flash) begin
      for (int b = 0; b < 4; b++) begin
        if (req_i.wstrb[b]) begin
          cust_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // flash writes still complete, they just change nothing
  assign rsp_o.ready = done;
  assign rsp_o.rdata = is_flash ? flash_q[idx] : cust_q[idx];

endmodule

// ==== verilog/psram_ctrl.sv ====
// PSRAM array controller with byte strobes, base wait states and an open-row penalty
`timescale 1ns/1ns

`include "mmap_params.svh"

module psram_ctrl
  import soc_bus_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  mem_req_t req_i,
  output mem_rsp_t rsp_o
);

  localparam int IDX_W = $clog2(`PSRAM_WORDS);
  localparam int CNT_W = $clog2(`PSRAM_WAIT + `PSRAM_ROW_PENALTY + 1);

  bus_addr_u        addr;
  logic [IDX_W-1:0] idx;
  logic [3:0]       row;
  logic             is_write;
  logic             row_miss;
  logic             accept;
  logic             done;
  logic [CNT_W-1:0] wait_ld;
  logic             busy_q;
  logic [CNT_W-1:0] cnt_q;
  logic [3:0]       row_q;
  logic             row_vld_q;
  logic [31:0]      mem_q [`PSRAM_WORDS];

  assign addr     = req_i.addr;
  // word index wraps on the array depth
  assign idx      = addr.f.offset[IDX_W+1:2];
  assign row      = addr.f.offset[7:4];
  assign is_write = |req_i.wstrb;

  // a closed row after reset always counts as a miss
  assign row_miss = !row_vld_q || (row != row_q);

  // base wait, plus the penalty when another row must be opened
  assign wait_ld = CNT_W'(`PSRAM_WAIT - 1) +
                   (row_miss ? CNT_W'(`PSRAM_ROW_PENALTY) : CNT_W'(0));

  assign accept = req_i.valid && !busy_q;
  assign done   = busy_q && (cnt_q == '0);

  // request sequencing
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (accept) begin
      busy_q <= 1'b1;
      cnt_q  <= wait_ld;
    end else if (done) begin
      busy_q <= 1'b0;
    end else if (busy_q) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // open-row tracking, updated as each request starts
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      row_vld_q <= 1'b0;
      row_q     <= '0;
    end else if (accept) begin
      row_vld_q <= 1'b1;
      row_q     <= row;
    end
  end

  // array write at the end of the wait
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `PSRAM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (done && is_write) begin
      for (int b = 0; b < 4; b++) begin
        if (req_i.wstrb[b]) begin
          mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // address is held by the requester until ready, so a direct read is stable
  assign rsp_o.ready = done;
  assign rsp_o.rdata = mem_q[idx];

endmodule

// ==== verilog/soc_mem_top.sv ====
// memory subsystem top level: bus decoder with native, mmap and PSRAM targets
`timescale 1ns/1ns

module soc_mem_top
  import soc_bus_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  mem_req_t core_req_i,
  output mem_rsp_t core_rsp_o
);

  mem_req_t natv_req;
  mem_rsp_t natv_rsp;
  mem_req_t mmap_req;
  mem_rsp_t mmap_rsp;
  mem_req_t psram_req;
  mem_rsp_t psram_rsp;

  bus u_bus (
    .core_req_i  (core_req_i),
    .core_rsp_o  (core_rsp_o),
    .natv_req_o  (natv_req),
    .natv_rsp_i  (natv_rsp),
    .mmap_req_o  (mmap_req),
    .mmap_rsp_i  (mmap_rsp),
    .psram_req_o (psram_req),
    .psram_rsp_i (psram_rsp)
  );

  natv_regs u_natv_regs (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (natv_req),
    .rsp_o   (natv_rsp)
  );

  // flash and custom IP share one target
  mmap_mem u_mmap_mem (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (mmap_req),
    .rsp_o   (mmap_rsp)
  );

  psram_ctrl u_psram_ctrl (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (psram_req),
    .rsp_o   (psram_rsp)
  );

endmodule

// ==== verification/tb_soc_mem.sv ====
// memory subsystem testbench with clock, reset, request stimulus, reference model and checker
`timescale 1ns/1ns

`include "mmap_params.svh"

module tb_soc_mem
  import soc_bus_pkg::*;
();

  // about 500 requests at up to 6 cycles each plus margin
  localparam int MAX_CYCLES  = 6000;
  localparam int READY_LIMIT = 16;

  // expected response of one request where only reads are compared
  typedef struct packed {
    logic        check;
    logic [31:0] data;
  } expect_t;

  logic     clk_i;
  logic     reset_i;
  mem_req_t core_req;
  mem_rsp_t core_rsp;

  expect_t     exp_q [$];
  expect_t     cmp_item;
  int          cycle_count;
  int unsigned sel_word;
  logic [7:0]  sel_region;
  logic [3:0]  sel_strb;
  logic [31:0] rd;

  // reference copies of every writable location
  logic [31:0] natv_shadow [`NATV_REGS];
  logic [31:0] cust_shadow [`MMAP_WORDS];
  logic [31:0] psram_shadow [`PSRAM_WORDS];

  soc_mem_top dut_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .core_req_i (core_req),
    .core_rsp_o (core_rsp)
  );

  always #4 clk_i = ~clk_i;

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("sim failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] window_addr(input logic [7:0] region, input int unsigned word);
    return {region, word[21:0], 2'b00};
  endfunction

  // byte lanes with a strobe bit take the new data
  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                              input logic [3:0] wstrb);
    logic [31:0] merged;
    merged = old;
    for (int b = 0; b < 4; b++) begin
      if (wstrb[b]) begin
        merged[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return merged;
  endfunction

  // returns the contents seen by the request and applies its write to the shadows
  function automatic logic [31:0] model_access(input logic [31:0] addr, input logic [31:0] wdata,
                                               input logic [3:0] wstrb);
    logic [7:0]  region;
    int unsigned word;
    int unsigned idx;
    logic [15:0] low;
    logic [31:0] old;
    region = addr[31:24];
    word   = 32'(addr[23:2]);
    old    = '0;
    if (region == `NATV_IP_START) begin
      if (word == 0) begin
        old = `NATV_ID;
      end else begin
        idx              = word % `NATV_REGS;
        old              = natv_shadow[idx];
        natv_shadow[idx] = merge_bytes(old, wdata, wstrb);
      end
    end else if (region == `FLASH_START) begin
      // flash ignores writes
      low = 16'(word % `MMAP_WORDS);
      old = {~low, low};
    end else if (region == `CUST_IP_START) begin
      idx              = word % `MMAP_WORDS;
      old              = cust_shadow[idx];
      cust_shadow[idx] = merge_bytes(old, wdata, wstrb);
    end else if (region == `PSRAM_START) begin
      idx               = word % `PSRAM_WORDS;
      old               = psram_shadow[idx];
      psram_shadow[idx] = merge_bytes(old, wdata, wstrb);
    end
    return old;
  endfunction

  // one request, held until ready, rdata sampled in the ready cycle
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output logic [31:0] rdata);
    expect_t item;
    int      waited;
    logic    seen;
    item.check = (wstrb == 4'h0);
    item.data  = model_access(addr, wdata, wstrb);
    waited     = 0;
    seen       = 1'b0;
    @(posedge clk_i);
    #1;
    core_req.valid = 1'b1;
    core_req.addr  = addr;
    core_req.wdata = wdata;
    core_req.wstrb = wstrb;
    exp_q.push_back(item);
    while (!seen) begin
      @(negedge clk_i);
      if (core_rsp.ready) begin
        seen  = 1'b1;
        rdata = core_rsp.rdata;
      end else if (waited == READY_LIMIT) begin
        stop_with_failure($sformatf("ready never came for address %08h within %0d cycles",
                                    addr, READY_LIMIT));
      end else begin
        waited++;
      end
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
      core_req.valid = 1'b0;
    end
  endtask

  // full write, partial write on top of it, then read back
  task automatic write_merge_read(input logic [7:0] region, input int unsigned word);
    logic [3:0] strb;
    strb = 4'($urandom_range(1, 14));
    bus_access(window_addr(region, word), $urandom, 4'hf, rd);
    bus_access(window_addr(region, word), $urandom, strb, rd);
    bus_access(window_addr(region, word), 32'h0, 4'h0, rd);
  endtask

  // compare process takes one expected entry per ready pulse
  always @(negedge clk_i) begin
    if (!reset_i && core_rsp.ready) begin
      assert (exp_q.size() > 0)
        else stop_with_failure("ready pulse arrived with no request outstanding");
      cmp_item = exp_q.pop_front();
      if (cmp_item.check) begin
        assert (core_rsp.rdata == cmp_item.data)
          else stop_with_failure($sformatf("FAIL t=%0t core_rsp_o.rdata got %08h expected %08h",
                                           $time, core_rsp.rdata, cmp_item.data));
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count == MAX_CYCLES) begin
      stop_with_failure($sformatf("run did not finish within %0d cycles", MAX_CYCLES));
    end
  end

  initial begin
    void'($urandom(32'h0f44_d5df));
    clk_i       = 1'b0;
    reset_i     = 1'b1;
    core_req    = '0;
    cycle_count = 0;
    for (int i = 0; i < `NATV_REGS; i++) begin
      natv_shadow[i] = '0;
    end
    for (int i = 0; i < `MMAP_WORDS; i++) begin
      cust_shadow[i] = '0;
    end
    for (int i = 0; i < `PSRAM_WORDS; i++) begin
      psram_shadow[i] = '0;
    end
    repeat (4) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    // identification word read before and after a write attempt
    bus_access(window_addr(`NATV_IP_START, 0), 32'h0, 4'h0, rd);
    assert (rd == `NATV_ID)
      else stop_with_failure($sformatf("FAIL t=%0t core_rsp_o.rdata got %08h expected %08h",
                                       $time, rd, `NATV_ID));
    bus_access(window_addr(`NATV_IP_START, 0), $urandom, 4'hf, rd);
    bus_access(window_addr(`NATV_IP_START, 0), 32'h0, 4'h0, rd);
    assert (rd == `NATV_ID)
      else stop_with_failure($sformatf("FAIL t=%0t core_rsp_o.rdata got %08h expected %08h",
                                       $time, rd, `NATV_ID));

    // byte merge in every writable window with some offsets past the depth
    for (int i = 0; i < 8; i++) begin
      write_merge_read(`NATV_IP_START, i + 1);
      write_merge_read(`CUST_IP_START, i * 9 + 32);
      write_merge_read(`PSRAM_START, i * 37);
    end

    // flash pattern survives writes
    for (int i = 0; i < 8; i++) begin
      sel_word = $urandom_range(0, 255);
      bus_access(window_addr(`FLASH_START, sel_word), 32'h0, 4'h0, rd);
      bus_access(window_addr(`FLASH_START, sel_word), $urandom, 4'hf, rd);
      bus_access(window_addr(`FLASH_START, sel_word), 32'h0, 4'h0, rd);
    end

    // mixed traffic that is mostly back to back
    for (int n = 0; n < 360; n++) begin
      case ($urandom_range(0, 3))
        0: begin
          sel_region = `NATV_IP_START;
          sel_word   = $urandom_range(0, 15);
        end
        1: begin
          sel_region = `FLASH_START;
          sel_word   = $urandom_range(0, 127);
        end
        2: begin
          sel_region = `CUST_IP_START;
          sel_word   = $urandom_range(0, 127);
        end
        default: begin
          sel_region = `PSRAM_START;
          sel_word   = $urandom_range(0, 511);
        end
      endcase
      sel_strb = $urandom_range(0, 1) ? 4'($urandom_range(1, 15)) : 4'h0;
      bus_access(window_addr(sel_region, sel_word), $urandom, sel_strb, rd);
      if ($urandom_range(0, 3) == 0) begin
        idle_cycles(1);
      end
    end

    // PSRAM rows 3 and 12 alternate so every access opens the other row
    for (int i = 0; i < 8; i++) begin
      bus_access(window_addr(`PSRAM_START, (i / 4) * 64 + 12 + i % 4), $urandom, 4'hf, rd);
      bus_access(window_addr(`PSRAM_START, (i / 4) * 64 + 48 + i % 4), $urandom, 4'hf, rd);
      bus_access(window_addr(`PSRAM_START, (i / 4) * 64 + 12 + i % 4), $urandom, 4'h6, rd);
      bus_access(window_addr(`PSRAM_START, (i / 4) * 64 + 48 + i % 4), 32'h0, 4'h0, rd);
      bus_access(window_addr(`PSRAM_START, (i / 4) * 64 + 12 + i % 4), 32'h0, 4'h0, rd);
    end

    // then a run inside row 7 only
    for (int c = 0; c < 4; c++) begin
      bus_access(window_addr(`PSRAM_START, 128 + 28 + c), $urandom, 4'hf, rd);
      bus_access(window_addr(`PSRAM_START, 128 + 28 + c), $urandom, 4'($urandom_range(1, 14)), rd);
    end
    for (int c = 0; c < 4; c++) begin
      bus_access(window_addr(`PSRAM_START, 128 + 28 + c), 32'h0, 4'h0, rd);
    end

    // quiet tail catches any late extra ready
    idle_cycles(8);
    $display("sim passed");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+verilog
verilog/soc_bus_pkg.sv
verilog/bus.sv
verilog/natv_regs.sv
verilog/mmap_mem.sv
verilog/psram_ctrl.sv
verilog/soc_mem_top.sv
verification/tb_soc_mem.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -Wno-fatal -j 0
TOP       ?= tb_soc_mem
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
PASS_MSG  := sim passed

SOURCES := $(wildcard verilog/*.sv verilog/*.svh verification/*.sv)
SIM_BIN := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
